/* Makefile */
TOP := rvseed_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Mdir obj_dir \
		--top-module $(TOP) -f all.f

# the output is echoed to stderr and searched for the pass line
run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q -F '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

/* all.f */
+incdir+rtl
rtl/rvseed_pkg.sv
rtl/mem_bus_if.sv
rtl/muxpc.sv
rtl/exec_core.sv
rtl/fetch_unit.sv
rtl/bus_arbiter.sv
rtl/shared_mem.sv
rtl/rvseed_top.sv
dv/rvseed_assertions.sv
dv/rvseed_tb.sv

/* dv/rvseed_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module rvseed_assertions (
   input logic clk,
   input logic rst_n,
   input logic host_req,
   input logic data_req,
   input logic fetch_req,
   input logic host_gnt,
   input logic data_gnt,
   input logic fetch_gnt
);
   logic [2:0] gnts;
   logic [2:0] reqs;

   assign gnts = {host_gnt, data_gnt, fetch_gnt};
   assign reqs = {host_req, data_req, fetch_req};

   a_one_gnt: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnts))
      else $error("more than one grant in one cycle");

   a_gnt_has_req: assert property (@(posedge clk) disable iff (!rst_n) (gnts & ~reqs) == 3'b0)
      else $error("grant given to a requester without req");

   a_no_gnt_in_reset: assert property (@(posedge clk) !rst_n |-> gnts == 3'b0)
      else $error("grant during reset");
endmodule

bind bus_arbiter rvseed_assertions u_assertions (
   .clk       (clk),
   .rst_n     (rst_n),
   .host_req  (host_bus.req),
   .data_req  (data_bus.req),
   .fetch_req (fetch_bus.req),
   .host_gnt  (host_bus.gnt),
   .data_gnt  (data_bus.gnt),
   .fetch_gnt (fetch_bus.gnt)
);

`default_nettype wire

/* dv/rvseed_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvseed_defs.svh"

module rvseed_tb;
   localparam int DATA_WORD = 128;  // byte 1024 held in x10
   localparam int DATA_LEN  = 16;

   logic                  clk = 1'b0;
   logic                  rst_n;
   logic                  start;
   logic                  host_req;
   logic                  host_we;
   logic [`CPU_WIDTH-1:0] host_addr;
   logic [`CPU_WIDTH-1:0] host_wdata;
   logic                  host_gnt;
   logic [`CPU_WIDTH-1:0] host_rdata;
   logic                  halted;
   logic                  retire_valid;
   logic [`CPU_WIDTH-1:0] retire_pc;

   logic [`CPU_WIDTH-1:0] ref_mem [`MEM_WORDS];
   logic [`CPU_WIDTH-1:0] ref_regs [`REG_DATA_DEPTH];
   logic [`CPU_WIDTH-1:0] ref_pc;
   logic                  ref_halted;
   logic                  seen_halt;
   logic [31:0]           prog [$];
   integer                seed = 32'h3f8f7377;
   int                    errors = 0;
   int                    checks = 0;
   int                    prog_words;

   rvseed_top dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (start),
      .host_req     (host_req),
      .host_we      (host_we),
      .host_addr    (host_addr),
      .host_wdata   (host_wdata),
      .host_gnt     (host_gnt),
      .host_rdata   (host_rdata),
      .halted       (halted),
      .retire_valid (retire_valid),
      .retire_pc    (retire_pc)
   );

   always #5 clk = ~clk;

   task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   function automatic logic [31:0] itype(input logic [6:0] opc, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [11:0] imm);
      return {imm, rs1, 3'b011 & {3{opc == rvseed_pkg::opc_load}}, rd, opc};  // ld uses 011
   endfunction

   function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [4:0] rd);
      return {f7, rs2, rs1, 3'b000, rd, rvseed_pkg::opc_op};
   endfunction

   function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], rvseed_pkg::opc_store};
   endfunction

   function automatic logic [31:0] btype(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] imm);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvseed_pkg::opc_branch};
   endfunction

   function automatic logic [31:0] jtype(input logic [4:0] rd, input logic [20:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvseed_pkg::opc_jal};
   endfunction

   // steps one instruction on the model state and returns the next pc
   function automatic logic [63:0] ref_step(input logic [63:0] pc);
      rvseed_pkg::instr_u ins;
      logic [31:0]        w;
      logic [63:0]        a, b, addr, nxt, res;
      logic [63:0]        imm_i, imm_s, imm_b, imm_j;
      logic               wr;
      logic               take;
      w     = pc[2] ? ref_mem[pc[11:3]][63:32] : ref_mem[pc[11:3]][31:0];
      ins   = w;
      a     = ref_regs[ins.i.rs1];
      b     = ref_regs[ins.sb.rs2];
      imm_i = {{52{w[31]}}, w[31:20]};
      imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
      imm_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      nxt   = pc + 64'd4;
      res   = pc + 64'd4;  // link value
      wr    = 1'b0;
      take  = 1'b0;
      case (ins.i.opcode)
         rvseed_pkg::opc_op_imm: begin
            res = a + imm_i;
            wr  = 1'b1;
         end
         rvseed_pkg::opc_op: begin
            res = w[30] ? a - b : a + b;
            wr  = 1'b1;
         end
         rvseed_pkg::opc_load: begin
            addr = a + imm_i;
            res  = ref_mem[addr[11:3]];
            wr   = 1'b1;
         end
         rvseed_pkg::opc_store: begin
            addr = a + imm_s;
            ref_mem[addr[11:3]] = b;
         end
         rvseed_pkg::opc_branch: begin
            case (ins.sb.funct3)
               rvseed_pkg::br_beq:  take = a == b;
               rvseed_pkg::br_bne:  take = a != b;
               rvseed_pkg::br_blt:  take = $signed(a) < $signed(b);
               rvseed_pkg::br_bge:  take = $signed(a) >= $signed(b);
               rvseed_pkg::br_bltu: take = a < b;
               default:             take = a >= b;
            endcase
            if (take) nxt = pc + imm_b;
         end
         rvseed_pkg::opc_jal: begin
            nxt = pc + imm_j;
            wr  = 1'b1;
         end
         rvseed_pkg::opc_jalr: begin
            nxt = (a + imm_i) & ~64'd1;
            wr  = 1'b1;
         end
         rvseed_pkg::opc_system: begin
            ref_halted = 1'b1;
            nxt        = pc;
         end
         default: begin
            errors++;
            $display("reference hit an unsupported opcode at pc %h", pc);
         end
      endcase
      if (wr && ins.i.rd != 5'd0) ref_regs[ins.i.rd] = res;
      return nxt;
   endfunction

   task automatic build_program();
      rvseed_pkg::br_func_e funcs [6];
      int                   target;
      funcs = '{rvseed_pkg::br_beq, rvseed_pkg::br_bne, rvseed_pkg::br_blt,
                rvseed_pkg::br_bge, rvseed_pkg::br_bltu, rvseed_pkg::br_bgeu};
      prog.push_back(itype(rvseed_pkg::opc_op_imm, 5'd10, 5'd0, 12'd1024));
      prog.push_back(itype(rvseed_pkg::opc_load, 5'd5, 5'd10, 12'd0));
      prog.push_back(itype(rvseed_pkg::opc_load, 5'd6, 5'd10, 12'd8));
      prog.push_back(itype(rvseed_pkg::opc_op_imm, 5'd1, 5'd0, 12'd100));
      prog.push_back(itype(rvseed_pkg::opc_op_imm, 5'd2, 5'd0, 12'hff9));  // -7
      prog.push_back(rtype(7'h00, 5'd2, 5'd1, 5'd3));
      prog.push_back(rtype(7'h20, 5'd2, 5'd1, 5'd4));
      prog.push_back(stype(12'd64, 5'd3, 5'd10));
      prog.push_back(stype(12'd72, 5'd4, 5'd10));
      prog.push_back(itype(rvseed_pkg::opc_op_imm, 5'd0, 5'd0, 12'd5));   // x0 must stay 0
      prog.push_back(stype(12'd80, 5'd0, 5'd10));
      prog.push_back(stype(12'd88, 5'd5, 5'd10));
      prog.push_back(itype(rvseed_pkg::opc_op_imm, 5'd20, 5'd0, 12'd0));  // not-taken count
      foreach (funcs[f]) begin
         for (int p = 0; p < 3; p++) begin
            prog.push_back(btype(funcs[f], p == 1 ? 5'd6 : 5'd5, p == 0 ? 5'd6 : 5'd5, 13'd8));
            prog.push_back(itype(rvseed_pkg::opc_op_imm, 5'd20, 5'd20, 12'd1));
         end
      end
      prog.push_back(stype(12'd96, 5'd20, 5'd10));
      prog.push_back(jtype(5'd1, 21'd8));
      prog.push_back(itype(rvseed_pkg::opc_op_imm, 5'd21, 5'd0, 12'd1));  // skipped
      prog.push_back(stype(12'd104, 5'd1, 5'd10));
      target = (prog.size() + 3) * 4;
      prog.push_back(itype(rvseed_pkg::opc_op_imm, 5'd11, 5'd0, target[11:0]));
      prog.push_back(itype(rvseed_pkg::opc_jalr, 5'd2, 5'd11, 12'd1));   // odd target
      prog.push_back(itype(rvseed_pkg::opc_op_imm, 5'd22, 5'd0, 12'd1));
      prog.push_back(stype(12'd112, 5'd2, 5'd10));
      prog.push_back(32'h00100073);  // ebreak
      if (prog.size() % 2 != 0) prog.push_back(32'h00000013);
      prog_words = prog.size() / 2;
   endtask

   task automatic fill_model();
      foreach (ref_regs[r]) ref_regs[r] = '0;
      for (int w = 0; w < prog_words; w++) ref_mem[w] = {prog[2*w+1], prog[2*w]};
      for (int w = DATA_WORD; w < DATA_WORD + DATA_LEN; w++) ref_mem[w] = {32'hc0de0000 ^ w, ~w};
      ref_mem[DATA_WORD]     = {$random(seed), $random(seed)};  // branch operands
      ref_mem[DATA_WORD + 1] = {$random(seed), $random(seed)};
      ref_mem[DATA_WORD + 1][63] = ~ref_mem[DATA_WORD][63];  // opposite signs
   endtask

   // starts and ends on a falling edge
   task automatic host_access(input logic we, input int word, input logic [63:0] wdata,
                              output logic [63:0] rdata);
      host_req   = 1'b1;
      host_we    = we;
      host_addr  = 64'(word) << 3;
      host_wdata = wdata;
      do @(posedge clk); while (!host_gnt);
      @(negedge clk);
      rdata    = host_rdata;
      host_req = 1'b0;
   endtask

   task automatic write_region(input int first, input int count);
      logic [63:0] rd;
      for (int w = first; w < first + count; w++) host_access(1'b1, w, ref_mem[w], rd);
   endtask

   task automatic verify_region(input int first, input int count, input string what);
      logic [63:0] rd;
      for (int w = first; w < first + count; w++) begin
         host_access(1'b0, w, '0, rd);
         check_equal(rd, ref_mem[w], $sformatf("%s word %0d", what, w));
      end
   endtask

   always @(negedge clk) begin
      logic [63:0] exp_pc;
      if (rst_n && retire_valid) begin
         if (seen_halt) begin
            errors++;
            $display("retire_valid pulsed at %0t ns after the core halted", $time);
         end else begin
            exp_pc = ref_step(ref_pc);
            check_equal(retire_pc, exp_pc, $sformatf("retire_pc of pc %h", ref_pc));
            check_equal(64'(halted), 64'(ref_halted), "halted at retire");
            ref_pc = exp_pc;
         end
      end
      if (rst_n && halted) seen_halt = 1'b1;
   end

   initial begin
      int limit;
      #1;
      limit = 10 + 8 * (prog_words + 2 * DATA_LEN) + 40 * prog.size() + 40;
      repeat (limit) @(posedge clk);
      $display("watchdog expired after %0d cycles without the run ending", limit);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      rst_n      = 1'b0;
      start      = 1'b0;
      host_req   = 1'b0;
      host_we    = 1'b0;
      host_addr  = '0;
      host_wdata = '0;
      ref_pc     = `RESET_PC;
      ref_halted = 1'b0;
      seen_halt  = 1'b0;
      build_program();
      fill_model();
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      write_region(0, prog_words);
      write_region(DATA_WORD, DATA_LEN);
      verify_region(0, prog_words, "program readback");
      verify_region(DATA_WORD, DATA_LEN, "data readback");
      start = 1'b1;
      wait (seen_halt);
      repeat (20) @(negedge clk);  // room for a stray retire
      verify_region(DATA_WORD, DATA_LEN, "data after halt");
      if (!ref_halted) begin
         errors++;
         $display("the core halted before the reference reached ebreak");
      end
      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end
endmodule

`default_nettype wire

/* rtl/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvseed_defs.svh"

module bus_arbiter (
   input  logic                           clk,
   input  logic                           rst_n,
   mem_bus_if.arbiter                     host_bus,
   mem_bus_if.arbiter                     data_bus,
   mem_bus_if.arbiter                     fetch_bus,
   output logic                           mem_en,
   output logic                           mem_we,
   output logic [$clog2(`MEM_WORDS)-1:0] mem_addr,
   output logic [`CPU_WIDTH-1:0]          mem_wdata,
   input  logic [`CPU_WIDTH-1:0]          mem_rdata
);
   localparam int AW = $clog2(`MEM_WORDS);

   rvseed_pkg::req_id_e sel;
   rvseed_pkg::req_id_e last_sel;
   logic                rd_pend;

   // host over data over fetch
   always_comb begin
      mem_en = 1'b1;
      if (host_bus.req) begin
         sel = rvseed_pkg::req_host;
      end else if (data_bus.req) begin
         sel = rvseed_pkg::req_data;
      end else if (fetch_bus.req) begin
         sel = rvseed_pkg::req_fetch;
      end else begin
         sel    = rvseed_pkg::req_host;
         mem_en = 1'b0;
      end
   end

   always_comb begin
      case (sel)
         rvseed_pkg::req_data: begin
            mem_we    = data_bus.we;
            mem_addr  = data_bus.addr[AW+2:3];
            mem_wdata = data_bus.wdata;
         end
         rvseed_pkg::req_fetch: begin
            mem_we    = fetch_bus.we;
            mem_addr  = fetch_bus.addr[AW+2:3];
            mem_wdata = fetch_bus.wdata;
         end
         default: begin
            mem_we    = host_bus.we;
            mem_addr  = host_bus.addr[AW+2:3];  // byte to word index
            mem_wdata = host_bus.wdata;
         end
      endcase
   end

   assign host_bus.gnt  = mem_en && sel == rvseed_pkg::req_host;
   assign data_bus.gnt  = mem_en && sel == rvseed_pkg::req_data;
   assign fetch_bus.gnt = mem_en && sel == rvseed_pkg::req_fetch;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_pend  <= 1'b0;
         last_sel <= rvseed_pkg::req_host;
      end else begin
         rd_pend  <= mem_en & ~mem_we;
         last_sel <= sel;
      end
   end

   // read data only to the requester granted last cycle
   assign host_bus.rdata  = (rd_pend && last_sel == rvseed_pkg::req_host) ? mem_rdata : '0;
   assign data_bus.rdata  = (rd_pend && last_sel == rvseed_pkg::req_data) ? mem_rdata : '0;
   assign fetch_bus.rdata = (rd_pend && last_sel == rvseed_pkg::req_fetch) ? mem_rdata : '0;
endmodule

`default_nettype wire

/* rtl/exec_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvseed_defs.svh"

module exec_core (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  instr_valid,
   input  rvseed_pkg::instr_u    instr,       // held by fetch until the next retire
   input  logic [`CPU_WIDTH-1:0] instr_pc,
   mem_bus_if.requester          data_bus,
   output logic                  retire,
   output logic                  halted,
   output logic [`CPU_WIDTH-1:0] next_pc
);
   localparam int W = `CPU_WIDTH;

   typedef enum logic [2:0] {s_idle, s_exec, s_mem, s_wait, s_done} state_e;

   state_e              state;
   rvseed_pkg::opcode_e opc;
   logic [W-1:0]        regs [`REG_DATA_DEPTH];
   logic [W-1:0]        rs1_val, rs2_val;
   logic [W-1:0]        imm_i, imm_s, imm_b, imm_j, pc_imm;
   logic [W-1:0]        wb_val;
   logic [W-1:0]        ld_data;
   logic                is_load, is_store, is_mem, is_branch;
   logic                is_jal, is_jalr, is_system;
   logic                rd_we;
   logic                halt_q;

   assign opc       = rvseed_pkg::opcode_e'(instr.i.opcode);
   assign is_load   = opc == rvseed_pkg::opc_load;
   assign is_store  = opc == rvseed_pkg::opc_store;
   assign is_mem    = is_load | is_store;
   assign is_branch = opc == rvseed_pkg::opc_branch;
   assign is_jal    = opc == rvseed_pkg::opc_jal;
   assign is_jalr   = opc == rvseed_pkg::opc_jalr;
   assign is_system = opc == rvseed_pkg::opc_system;  // ebreak only
   assign rd_we     = is_load | is_jal | is_jalr | opc == rvseed_pkg::opc_op_imm
                      | opc == rvseed_pkg::opc_op;

   assign rs1_val = (instr.i.rs1 == 5'd0) ? '0 : regs[instr.i.rs1];
   assign rs2_val = (instr.sb.rs2 == 5'd0) ? '0 : regs[instr.sb.rs2];

   assign imm_i = {{(W-12){instr.i.imm[11]}}, instr.i.imm};
   assign imm_s = {{(W-12){instr.sb.imm_hi[6]}}, instr.sb.imm_hi, instr.sb.imm_lo};
   assign imm_b = {{(W-13){instr.sb.imm_hi[6]}}, instr.sb.imm_hi[6], instr.sb.imm_lo[0],
                   instr.sb.imm_hi[5:0], instr.sb.imm_lo[4:1], 1'b0};
   // J immediate sits across the I-view fields
   assign imm_j = {{(W-21){instr.i.imm[11]}}, instr.i.imm[11], instr.i.rs1, instr.i.funct3,
                   instr.i.imm[0], instr.i.imm[10:1], 1'b0};
   assign pc_imm = is_jal ? imm_j : (is_jalr ? imm_i : imm_b);

   always_comb begin
      case (opc)
         rvseed_pkg::opc_op_imm: wb_val = rs1_val + imm_i;
         rvseed_pkg::opc_op:     wb_val = instr.sb.imm_hi[5] ? rs1_val - rs2_val
                                                             : rs1_val + rs2_val;
         rvseed_pkg::opc_load:   wb_val = ld_data;
         default:                wb_val = instr_pc + W'(4);  // link value
      endcase
   end

   muxpc u_muxpc (
      .ena     (~is_system),
      .branch  (is_branch),
      .jump    (is_jal | is_jalr),
      .jalr    (is_jalr),
      .br_func (rvseed_pkg::br_func_e'(instr.sb.funct3)),
      .imm     (pc_imm),
      .curr_pc (instr_pc),
      .rs1_val (rs1_val),
      .rs2_val (rs2_val),
      .next_pc (next_pc),
      .taken   ()
   );

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state  <= s_idle;
         halt_q <= 1'b0;
      end else begin
         case (state)
            s_idle: if (instr_valid) state <= s_exec;
            s_exec: state <= is_mem ? s_mem : s_idle;
            s_mem:  if (data_bus.gnt) state <= is_load ? s_wait : s_done;
            s_wait: state <= s_done;
            default: state <= s_idle;
         endcase
         if (retire && is_system) halt_q <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (state == s_wait) ld_data <= data_bus.rdata;
      if (retire && rd_we && instr.i.rd != 5'd0) regs[instr.i.rd] <= wb_val;
   end

   assign data_bus.req   = state == s_mem;
   assign data_bus.we    = is_store;
   assign data_bus.addr  = rs1_val + (is_store ? imm_s : imm_i);
   assign data_bus.wdata = rs2_val;

   assign retire = (state == s_exec && !is_mem) || state == s_done;
   assign halted = halt_q | (retire & is_system);
endmodule

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvseed_defs.svh"

module fetch_unit (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  start,
   input  logic                  retire,
   input  logic                  halted,
   input  logic [`CPU_WIDTH-1:0] next_pc,
   mem_bus_if.requester          fetch_bus,
   output logic                  instr_valid,
   output logic [31:0]           instr,
   output logic [`CPU_WIDTH-1:0] instr_pc
);
   typedef enum logic [2:0] {f_idle, f_req, f_wait, f_run, f_stop} fstate_e;

   fstate_e               state;
   logic [`CPU_WIDTH-1:0] pc;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state       <= f_idle;
         pc          <= `RESET_PC;
         instr_valid <= 1'b0;
      end else begin
         instr_valid <= 1'b0;
         case (state)
            f_idle: if (start) state <= f_req;
            f_req:  if (fetch_bus.gnt) state <= f_wait;
            f_wait: begin
               state       <= f_run;
               instr_valid <= 1'b1;
            end
            f_run: begin
               if (retire && halted) begin
                  state <= f_stop;
               end else if (retire) begin
                  pc    <= next_pc;
                  state <= f_req;
               end
            end
            f_stop: state <= f_stop;  // only reset leaves
            default: state <= f_idle;
         endcase
      end
   end

   // pick the 32-bit half of the returned word
   always_ff @(posedge clk) begin
      if (state == f_wait) instr <= pc[2] ? fetch_bus.rdata[63:32] : fetch_bus.rdata[31:0];
   end

   assign instr_pc        = pc;
   assign fetch_bus.req   = state == f_req;
   assign fetch_bus.we    = 1'b0;
   assign fetch_bus.addr  = pc;
   assign fetch_bus.wdata = '0;
endmodule

`default_nettype wire

/* rtl/mem_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvseed_defs.svh"

interface mem_bus_if;
   logic                  req;
   logic                  we;
   logic [`CPU_WIDTH-1:0] addr;   // byte address
   logic [`CPU_WIDTH-1:0] wdata;
   logic                  gnt;    // one-cycle pulse
   logic [`CPU_WIDTH-1:0] rdata;  // valid the cycle after gnt

   modport requester (output req, we, addr, wdata, input gnt, rdata);
   modport arbiter (input req, we, addr, wdata, output gnt, rdata);
endinterface

`default_nettype wire

/* rtl/muxpc.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvseed_defs.svh"

module muxpc (
   input  logic                  ena,
   input  logic                  branch,
   input  logic                  jump,
   input  logic                  jalr,
   input  rvseed_pkg::br_func_e  br_func,
   input  logic [`CPU_WIDTH-1:0] imm,
   input  logic [`CPU_WIDTH-1:0] curr_pc,
   input  logic [`CPU_WIDTH-1:0] rs1_val,
   input  logic [`CPU_WIDTH-1:0] rs2_val,
   output logic [`CPU_WIDTH-1:0] next_pc,
   output logic                  taken
);
   logic                  eq;
   logic                  lt_s;
   logic                  lt_u;
   logic                  cond;
   logic [`CPU_WIDTH-1:0] jalr_tgt;

   assign eq   = rs1_val == rs2_val;
   assign lt_s = $signed(rs1_val) < $signed(rs2_val);
   assign lt_u = rs1_val < rs2_val;

   always_comb begin
      case (br_func)
         rvseed_pkg::br_beq:  cond = eq;
         rvseed_pkg::br_bne:  cond = ~eq;
         rvseed_pkg::br_blt:  cond = lt_s;
         rvseed_pkg::br_bge:  cond = ~lt_s;
         rvseed_pkg::br_bltu: cond = lt_u;
         rvseed_pkg::br_bgeu: cond = ~lt_u;
         default:             cond = 1'b0;
      endcase
   end

   assign taken    = branch & cond;
   assign jalr_tgt = rs1_val + imm;

   always_comb begin
      if (!ena) begin
         next_pc = curr_pc;                           // halted, hold pc
      end else if (jump && jalr) begin
         next_pc = {jalr_tgt[`CPU_WIDTH-1:1], 1'b0};
      end else if (jump || taken) begin
         next_pc = curr_pc + imm;
      end else begin
         next_pc = curr_pc + `CPU_WIDTH'd4;
      end
   end
endmodule

`default_nettype wire

/* rtl/rvseed_defs.svh */
`ifndef RVSEED_DEFS_SVH
`define RVSEED_DEFS_SVH

// data path and address width
`define CPU_WIDTH 64

`define REG_DATA_DEPTH 32

// shared memory depth in 64-bit words
`define MEM_WORDS 512

`define RESET_PC 64'h0

`endif

/* rtl/rvseed_pkg.sv */
`default_nettype none

package rvseed_pkg;

   // one instruction word, read as I-format or as S/B-format
   typedef union packed {
      struct packed {
         logic [11:0] imm;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i;
      struct packed {
         logic [6:0] imm_hi;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] imm_lo;
         logic [6:0] opcode;
      } sb;
   } instr_u;

   typedef enum logic [6:0] {
      opc_op_imm = 7'b0010011,
      opc_op     = 7'b0110011,
      opc_load   = 7'b0000011,
      opc_store  = 7'b0100011,
      opc_branch = 7'b1100011,
      opc_jal    = 7'b1101111,
      opc_jalr   = 7'b1100111,
      opc_system = 7'b1110011
   } opcode_e;

   typedef enum logic [2:0] {
      br_beq  = 3'b000,
      br_bne  = 3'b001,
      br_blt  = 3'b100,
      br_bge  = 3'b101,
      br_bltu = 3'b110,
      br_bgeu = 3'b111
   } br_func_e;

   typedef enum logic [1:0] {
      req_host  = 2'd0,
      req_data  = 2'd1,
      req_fetch = 2'd2
   } req_id_e;

endpackage

`default_nettype wire

/* rtl/rvseed_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvseed_defs.svh"

module rvseed_top (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  start,
   input  logic                  host_req,
   input  logic                  host_we,
   input  logic [`CPU_WIDTH-1:0] host_addr,
   input  logic [`CPU_WIDTH-1:0] host_wdata,
   output logic                  host_gnt,
   output logic [`CPU_WIDTH-1:0] host_rdata,
   output logic                  halted,
   output logic                  retire_valid,
   output logic [`CPU_WIDTH-1:0] retire_pc
);
   mem_bus_if fetch_bus ();
   mem_bus_if data_bus ();
   mem_bus_if host_bus ();

   logic                           instr_valid;
   logic                           retire;
   logic [31:0]                    instr;
   logic [`CPU_WIDTH-1:0]          instr_pc;
   logic [`CPU_WIDTH-1:0]          next_pc;
   logic                           mem_en;
   logic                           mem_we;
   logic [$clog2(`MEM_WORDS)-1:0] mem_addr;
   logic [`CPU_WIDTH-1:0]          mem_wdata;
   logic [`CPU_WIDTH-1:0]          mem_rdata;

   assign host_bus.req   = host_req;
   assign host_bus.we    = host_we;
   assign host_bus.addr  = host_addr;
   assign host_bus.wdata = host_wdata;
   assign host_gnt       = host_bus.gnt;
   assign host_rdata     = host_bus.rdata;

   assign retire_valid = retire;
   assign retire_pc    = next_pc;

   fetch_unit u_fetch (
      .clk         (clk),
      .rst_n       (rst_n),
      .start       (start),
      .retire      (retire),
      .halted      (halted),
      .next_pc     (next_pc),
      .fetch_bus   (fetch_bus.requester),
      .instr_valid (instr_valid),
      .instr       (instr),
      .instr_pc    (instr_pc)
   );

   exec_core u_core (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .instr_pc    (instr_pc),
      .data_bus    (data_bus.requester),
      .retire      (retire),
      .halted      (halted),
      .next_pc     (next_pc)
   );

   bus_arbiter u_arb (
      .clk       (clk),
      .rst_n     (rst_n),
      .host_bus  (host_bus.arbiter),
      .data_bus  (data_bus.arbiter),
      .fetch_bus (fetch_bus.arbiter),
      .mem_en    (mem_en),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

   shared_mem u_mem (
      .clk       (clk),
      .mem_en    (mem_en),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );
endmodule

`default_nettype wire

/* rtl/shared_mem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvseed_defs.svh"

module shared_mem (
   input  logic                           clk,
   input  logic                           mem_en,
   input  logic                           mem_we,
   input  logic [$clog2(`MEM_WORDS)-1:0] mem_addr,
   input  logic [`CPU_WIDTH-1:0]          mem_wdata,
   output logic [`CPU_WIDTH-1:0]          mem_rdata
);
   logic [`CPU_WIDTH-1:0] mem [`MEM_WORDS];

   always_ff @(posedge clk) begin
      if (mem_en) begin
         if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
         end else begin
            mem_rdata <= mem[mem_addr];  // registered read
         end
      end
   end
endmodule

`default_nettype wire
